//--- rv_pipe.f
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/hazard_ctrl.sv
hw/execute_stage.sv
hw/mem_stage.sv
hw/rv_pipe_top.sv
sim/rv_pipe_checker.sv
sim/tb_rv_pipe.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --x-initial 0 \
	--top-module tb_rv_pipe -f rv_pipe.f -Mdir obj_dir

./obj_dir/Vtb_rv_pipe > sim.log
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
exit 0

//--- sim/tb_rv_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rv_pipe;

	localparam int N_TESTS = 8;
	localparam int RETIRE_TIMEOUT = 400;
	localparam int TRAIL = 24;	// quiet cycles after the last retire

	logic             clk;
	logic             arst_n;
	logic             imem_wr_valid;
	rv_pkg::imem_wr_t imem_wr;
	logic             imem_wr_ready;
	logic             start;
	logic             retire_valid;
	rv_pkg::retire_t  retire;
	logic [31:0]      prog [64];
	int               pending;
	int               tb_errors;

	rv_pipe_top #(.IMEM_WORDS(64), .DMEM_WORDS(64)) i_rv_pipe_top (
		.clk, .arst_n, .imem_wr_valid, .imem_wr, .imem_wr_ready, .start,
		.retire_valid, .retire
	);

	rv_pipe_checker i_checker (.clk, .retire_valid, .retire, .prog, .pending);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, 3'b000 | {1'b0, opc == 7'b0000011, 1'b0}, rd, opc};	// lw f3 = 010
	endfunction

	function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2);
		return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic bne);
		return {imm[12], imm[10:5], rs2, rs1, 2'b00, bne, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = $urandom;
		return {2'b00, r[2:0]};
	endfunction

	// seven register seeds, 32 random ops with forward-only control flow, then a self jump
	task automatic gen_program();
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		int          lim;
		int          k;
		for (int i = 0; i < 7; i++) begin
			r = $urandom;
			prog[i] = enc_i(r[11:0], 5'd0, 5'(i + 1), 7'b0010011);
		end
		for (int i = 7; i < 39; i++) begin
			r = $urandom;
			rd = pick_reg();
			rs1 = pick_reg();
			rs2 = pick_reg();
			lim = (39 - i < 4) ? 39 - i : 4;
			k = 1 + (int'(r[10:8]) % lim);
			case (r[3:0])
				4'd0, 4'd1, 4'd2, 4'd3, 4'd4: begin
					case (r[6:5])
						2'd0: prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, rd);
						2'd1: prog[i] = enc_r(7'h20, rs2, rs1, 3'b000, rd);
						2'd2: prog[i] = enc_r(7'h00, rs2, rs1, 3'b111, rd);
						default: prog[i] = enc_r(7'h00, rs2, rs1, 3'b110, rd);
					endcase
				end
				4'd5, 4'd6: prog[i] = enc_i(r[27:16], rs1, rd, 7'b0010011);
				4'd7, 4'd8: prog[i] = enc_i({4'd0, r[21:16], 2'b00}, 5'd0, rd, 7'b0000011);
				4'd9, 4'd10: prog[i] = enc_s({4'd0, r[21:16], 2'b00}, rs2);
				4'd11, 4'd12: prog[i] = enc_b(13'(k * 4), rs2, rs1, r[7]);
				4'd13: prog[i] = enc_j(21'(k * 4), rd);
				4'd14: prog[i] = enc_i(12'((i + k) * 4), 5'd0, rd, 7'b1100111);
				default: prog[i] = enc_r(7'h00, rs2, rs1, 3'b000, 5'd0);	// x0 sink
			endcase
		end
		prog[39] = enc_j(21'd0, 5'd0);
		for (int i = 40; i < 64; i++)
			prog[i] = 32'h00000013;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		arst_n = 1'b0;
		repeat (2) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic load_program();
		int cnt;
		for (int w = 0; w < 64; w++) begin
			@(negedge clk);
			cnt = 0;
			while (!imem_wr_ready && cnt < 20) begin
				@(negedge clk);
				cnt++;
			end
			if (!imem_wr_ready) begin
				tb_errors++;
				$display("load port never raised ready for word %0d", w);
				imem_wr_valid = 1'b0;
				return;
			end
			imem_wr_valid = 1'b1;
			imem_wr.addr = 32'(w);
			imem_wr.instr = prog[w];
		end
		@(negedge clk);
		imem_wr_valid = 1'b0;
	endtask

	task automatic run_test(input int t);
		int cnt;
		int errs_at_start;
		errs_at_start = tb_errors;
		apply_reset();
		gen_program();
		load_program();
		i_checker.build_expected();
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (imem_wr_ready) begin
			tb_errors++;
			$display("load port still ready after start");
		end
		cnt = 0;
		while (pending > 0 && cnt < RETIRE_TIMEOUT) begin
			@(posedge clk);
			cnt++;
		end
		if (pending > 0) begin
			tb_errors++;
			$display("timed out with %0d retirements still missing", pending);
		end
		cnt = 0;
		while (cnt < TRAIL) begin
			@(posedge clk);
			cnt++;
		end
		i_checker.end_test(t, tb_errors - errs_at_start);
	endtask

	initial begin
		arst_n = 1'b0;
		imem_wr_valid = 1'b0;
		imem_wr = '0;
		start = 1'b0;
		tb_errors = 0;
		void'($urandom(32'h698c));
		for (int t = 0; t < N_TESTS; t++)
			run_test(t);
		i_checker.print_counts(tb_errors);
		if (tb_errors == 0 && i_checker.errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule : tb_rv_pipe

`default_nettype wire

//--- sim/rv_pipe_checker.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_checker (
	input  logic            clk,
	input  logic            retire_valid,
	input  rv_pkg::retire_t retire,
	input  logic [31:0]     prog [64],
	output int              pending
);

	rv_pkg::retire_t exp_q[$];
	logic [31:0]     regs [32];
	logic [31:0]     mem_model [64];	// survives reset, like the data memory
	int              errors = 0;
	int              test_errors = 0;
	int              checked = 0;
	int              tests_ok = 0;
	int              tests_bad = 0;

	initial begin
		pending = 0;
		for (int i = 0; i < 64; i++)
			mem_model[i] = '0;
		for (int i = 0; i < 32; i++)
			regs[i] = '0;
	end

	task automatic put_reg(input logic [4:0] rd, input logic [31:0] v, input logic [31:0] pc);
		rv_pkg::retire_t e;
		if (rd != 5'd0) begin	// x0 writes vanish
			regs[rd] = v;
			e.kind = 1'b0;
			e.index = {27'd0, rd};
			e.value = v;
			e.pc = pc;
			exp_q.push_back(e);
		end
	endtask

	// instruction-level run of the program up to the final self jump
	task automatic build_expected();
		logic [31:0] pc;
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] addr;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		logic [31:0] next;
		rv_pkg::retire_t e;
		int steps;
		exp_q.delete();
		test_errors = 0;
		checked = 0;
		pc = '0;
		steps = 0;
		while (steps < 400 && prog[pc[7:2]] != 32'h0000006f) begin
			w = prog[pc[7:2]];
			a = (w[19:15] == 5'd0) ? '0 : regs[w[19:15]];
			b = (w[24:20] == 5'd0) ? '0 : regs[w[24:20]];
			imm_i = {{20{w[31]}}, w[31:20]};
			imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
			imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
			imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
			next = pc + 32'd4;
			case (w[6:0])
				7'b0110011: begin
					case (w[14:12])
						3'b000: put_reg(w[11:7], w[30] ? a - b : a + b, pc);
						3'b111: put_reg(w[11:7], a & b, pc);
						3'b110: put_reg(w[11:7], a | b, pc);
						default: ;
					endcase
				end
				7'b0010011: put_reg(w[11:7], a + imm_i, pc);
				7'b0000011: begin
					addr = a + imm_i;
					put_reg(w[11:7], mem_model[addr[7:2]], pc);
				end
				7'b0100011: begin
					addr = a + imm_s;
					mem_model[addr[7:2]] = b;
					e.kind = 1'b1;
					e.index = {2'b00, addr[31:2]};
					e.value = b;
					e.pc = pc;
					exp_q.push_back(e);
				end
				7'b1100011: if (w[12] ? (a != b) : (a == b)) next = pc + imm_b;
				7'b1101111: begin
					next = pc + imm_j;
					put_reg(w[11:7], pc + 32'd4, pc);
				end
				7'b1100111: begin
					next = (a + imm_i) & ~32'd1;	// target before the link write
					put_reg(w[11:7], pc + 32'd4, pc);
				end
				default: ;
			endcase
			pc = next;
			steps++;
		end
		if (steps >= 400) begin
			errors++;
			test_errors++;
			$display("reference model never reached the final jump");
		end
		pending = exp_q.size();
	endtask

	task automatic compare_field(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		if (exp_v !== got_v) begin
			errors++;
			test_errors++;
			$display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, exp_v, got_v);
		end
	endtask

	always @(negedge clk) begin
		rv_pkg::retire_t e;
		if (retire_valid) begin
			if (exp_q.size() == 0) begin
				errors++;
				test_errors++;
				$display("retire from pc 0x%08h arrived when none was expected", retire.pc);
			end else begin
				e = exp_q.pop_front();
				compare_field("retire.kind", {31'd0, e.kind}, {31'd0, retire.kind});
				compare_field("retire.index", e.index, retire.index);
				compare_field("retire.value", e.value, retire.value);
				compare_field("retire.pc", e.pc, retire.pc);
				checked++;
				pending = exp_q.size();
			end
		end
	end

	task automatic end_test(input int t, input int other_errors);
		$display("test %0d: %0d retires checked, %0d errors", t, checked,
			test_errors + other_errors);
		if (test_errors + other_errors == 0)
			tests_ok++;
		else
			tests_bad++;
	endtask

	task automatic print_counts(input int other_errors);
		$display("%0d tests clean, %0d tests with errors, %0d errors in total",
			tests_ok, tests_bad, errors + other_errors);
	endtask

endmodule : rv_pipe_checker

`default_nettype wire

//--- hw/rv_pipe_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_pipe_top #(
	parameter int IMEM_WORDS = 64,
	parameter int DMEM_WORDS = 64
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             imem_wr_valid,
	input  rv_pkg::imem_wr_t imem_wr,
	output logic             imem_wr_ready,
	input  logic             start,
	output logic             retire_valid,
	output rv_pkg::retire_t  retire
);

	logic [31:0]         instr_word;
	logic [31:0]         if_pc;
	rv_pkg::instr_t      instr_f, instr_d, instr_x, instr_m;
	logic                branch_actual;
	logic                redirect;
	logic [31:0]         redirect_pc;
	logic [31:0]         alu_result;
	rv_pkg::ex_pkt_t     ex_pkt;
	rv_pkg::mem_pkt_t    mem_pkt;
	rv_pkg::wb_pkt_t     wb;
	logic                ex_mem_wr_rd, mem_wb_wr_rd;
	rv_pkg::fwd_sel_t    fwd_a, fwd_b, fwd_m2m;
	rv_pkg::branch_fwd_t fwd_rs1, fwd_rs2;
	logic                stall_if_id, stall_id_ex, flush_if_id;

	fetch_stage #(.IMEM_WORDS(IMEM_WORDS)) i_fetch (
		.clk, .arst_n, .imem_wr_valid, .imem_wr, .imem_wr_ready, .start,
		.stall_if_id, .flush_if_id, .redirect, .redirect_pc,
		.instr_word, .if_pc, .instr_f
	);

	// branch operands by producer: execute, memory register, writeback register
	decode_stage i_decode (
		.clk, .arst_n, .instr_word, .if_pc, .fwd_rs1, .fwd_rs2,
		.ex_result(alu_result), .mem_result(mem_pkt.alu_out), .wb_result(wb.result),
		.wb, .stall_id_ex, .instr_d, .branch_actual, .redirect, .redirect_pc, .ex_pkt
	);

	hazard_ctrl i_hazard (
		.instr_f, .instr_d, .instr_x, .instr_m, .instr_w(wb.instr),
		.ex_mem_wr_rd, .mem_wb_wr_rd, .branch_actual,
		.fwd_a, .fwd_b, .fwd_m2m, .fwd_rs1, .fwd_rs2,
		.stall_if_id, .stall_id_ex, .flush_if_id
	);

	execute_stage i_execute (
		.clk, .arst_n, .ex_pkt, .fwd_a, .fwd_b,
		.ex_result(mem_pkt.alu_out), .mem_result(wb.result),
		.instr_x, .alu_result, .ex_mem_wr_rd, .mem_pkt
	);

	mem_stage #(.DMEM_WORDS(DMEM_WORDS)) i_mem (
		.clk, .arst_n, .mem_pkt, .fwd_m2m, .wb_result(wb.result),
		.instr_m, .mem_wb_wr_rd, .wb, .retire_valid, .retire
	);

endmodule : rv_pipe_top

`default_nettype wire

//--- hw/mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
	parameter int DMEM_WORDS = 64
) (
	input  logic             clk,
	input  logic             arst_n,
	input  rv_pkg::mem_pkt_t mem_pkt,
	input  rv_pkg::fwd_sel_t fwd_m2m,
	input  logic [31:0]      wb_result,
	output rv_pkg::instr_t   instr_m,
	output logic             mem_wb_wr_rd,
	output rv_pkg::wb_pkt_t  wb,
	output logic             retire_valid,
	output rv_pkg::retire_t  retire
);

	localparam int DW = $clog2(DMEM_WORDS);

	logic [31:0] dmem [DMEM_WORDS];
	logic [31:0] st_data;
	logic [31:0] ld_data;
	logic [31:0] result;
	logic        is_store;

	assign instr_m = mem_pkt.instr;
	assign mem_wb_wr_rd = wb.wr_rd;

	assign is_store = mem_pkt.valid && (mem_pkt.instr.opcode == rv_pkg::STORE);
	// load right before the store
	assign st_data = (fwd_m2m == rv_pkg::MEM_MEM_FWD_SEL) ? wb_result : mem_pkt.store_val;
	assign ld_data = dmem[mem_pkt.alu_out[DW+1:2]];
	assign result = (mem_pkt.instr.opcode == rv_pkg::LOAD) ? ld_data : mem_pkt.alu_out;

	always_ff @(posedge clk) begin
		if (is_store)
			dmem[mem_pkt.alu_out[DW+1:2]] <= st_data;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wb <= '0;
			retire_valid <= 1'b0;
			retire <= '0;
		end else begin
			wb.instr <= mem_pkt.instr;
			wb.result <= result;
			wb.wr_rd <= mem_pkt.wr_rd;
			wb.valid <= mem_pkt.valid;
			retire_valid <= mem_pkt.wr_rd || is_store;
			retire.kind <= is_store;
			retire.index <= is_store ? {2'b00, mem_pkt.alu_out[31:2]} :
				{27'd0, mem_pkt.instr.rd};
			retire.value <= is_store ? st_data : result;
			retire.pc <= mem_pkt.pc;
		end
	end

endmodule : mem_stage

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
	input  logic               clk,
	input  logic               arst_n,
	input  rv_pkg::ex_pkt_t    ex_pkt,
	input  rv_pkg::fwd_sel_t   fwd_a,
	input  rv_pkg::fwd_sel_t   fwd_b,
	input  logic [31:0]        ex_result,
	input  logic [31:0]        mem_result,
	output rv_pkg::instr_t     instr_x,
	output logic [31:0]        alu_result,	// also feeds branch compare in decode
	output logic               ex_mem_wr_rd,
	output rv_pkg::mem_pkt_t   mem_pkt
);

	logic [31:0] op_a;
	logic [31:0] op_b;
	logic        writes_rd;

	assign instr_x = ex_pkt.instr;
	assign ex_mem_wr_rd = mem_pkt.wr_rd;

	always_comb begin
		case (fwd_a)
			rv_pkg::EX_EX_FWD_SEL:  op_a = ex_result;
			rv_pkg::MEM_EX_FWD_SEL: op_a = mem_result;
			default:                op_a = ex_pkt.rs1_val;
		endcase
		case (fwd_b)
			rv_pkg::EX_EX_FWD_SEL:  op_b = ex_result;
			rv_pkg::MEM_EX_FWD_SEL: op_b = mem_result;
			default:                op_b = ex_pkt.rs2_val;
		endcase
	end

	always_comb begin
		case (ex_pkt.instr.opcode)
			rv_pkg::OP_ADD: alu_result = op_a + op_b;
			rv_pkg::OP_SUB: alu_result = op_a - op_b;
			rv_pkg::OP_AND: alu_result = op_a & op_b;
			rv_pkg::OP_OR:  alu_result = op_a | op_b;
			rv_pkg::OP_ADDI, rv_pkg::LOAD, rv_pkg::STORE:
				alu_result = op_a + ex_pkt.instr.imm;	// sum or address
			rv_pkg::JAL, rv_pkg::JALR:
				alu_result = ex_pkt.pc + 32'd4;	// link value
			default: alu_result = '0;
		endcase
	end

	// stores and branches carry rd = x0
	assign writes_rd = ex_pkt.valid && (ex_pkt.instr.rd != rv_pkg::X0);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			mem_pkt <= '0;
		end else begin
			mem_pkt.instr <= ex_pkt.instr;
			mem_pkt.pc <= ex_pkt.pc;
			mem_pkt.alu_out <= alu_result;
			mem_pkt.store_val <= op_b;
			mem_pkt.wr_rd <= writes_rd;
			mem_pkt.valid <= ex_pkt.valid;
		end
	end

endmodule : execute_stage

`default_nettype wire

//--- hw/hazard_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_ctrl (
	input  rv_pkg::instr_t      instr_f,
	input  rv_pkg::instr_t      instr_d,
	input  rv_pkg::instr_t      instr_x,
	input  rv_pkg::instr_t      instr_m,
	input  rv_pkg::instr_t      instr_w,
	input  logic                ex_mem_wr_rd,
	input  logic                mem_wb_wr_rd,
	input  logic                branch_actual,
	output rv_pkg::fwd_sel_t    fwd_a,
	output rv_pkg::fwd_sel_t    fwd_b,
	output rv_pkg::fwd_sel_t    fwd_m2m,
	output rv_pkg::branch_fwd_t fwd_rs1,
	output rv_pkg::branch_fwd_t fwd_rs2,
	output logic                stall_if_id,
	output logic                stall_id_ex,
	output logic                flush_if_id
);

	rv_pkg::r_t ex_mem_rd;
	rv_pkg::r_t mem_wb_rd;
	logic mem_store, mem_load;
	logic d_cmp;	// decode needs operands now (branch or jalr)
	logic jump;

	logic hazard_1a, hazard_1b;	// ex - ex
	logic hazard_2a, hazard_2b;	// mem - ex
	logic hazard_3;	// mem - mem, store data
	logic hazard_4a, hazard_4b;	// load in execute feeds decode
	logic hazard_5a, hazard_5b;	// load - whatever - branch
	logic hazard_6a, hazard_6b;	// branch operand from execute
	logic hazard_7a, hazard_7b;	// from memory
	logic hazard_8a, hazard_8b;	// from writeback

	assign ex_mem_rd = instr_m.rd;
	assign mem_wb_rd = instr_w.rd;
	assign mem_store = (instr_m.opcode == rv_pkg::STORE);
	assign mem_load = (instr_m.opcode == rv_pkg::LOAD);
	assign d_cmp = (instr_d.opcode == rv_pkg::B) || (instr_d.opcode == rv_pkg::JALR);
	assign jump = (instr_d.opcode == rv_pkg::JAL) || (instr_d.opcode == rv_pkg::JALR);

	always_comb begin
		// a load in memory only has its address in alu_out
		hazard_1a = ex_mem_wr_rd && !mem_load && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_x.rs1);
		hazard_1b = ex_mem_wr_rd && !mem_load && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_x.rs2);
		// most recent producer wins
		hazard_2a = mem_wb_wr_rd && !hazard_1a && (mem_wb_rd != rv_pkg::X0) &&
			(mem_wb_rd == instr_x.rs1);
		hazard_2b = mem_wb_wr_rd && !hazard_1b && (mem_wb_rd != rv_pkg::X0) &&
			(mem_wb_rd == instr_x.rs2);
		hazard_3 = mem_store && mem_wb_wr_rd && (mem_wb_rd != rv_pkg::X0) &&
			(mem_wb_rd == instr_m.rs2);
	end

	always_comb begin
		fwd_a = hazard_1a ? rv_pkg::EX_EX_FWD_SEL :
			hazard_2a ? rv_pkg::MEM_EX_FWD_SEL : rv_pkg::RS_SEL;
		fwd_b = hazard_1b ? rv_pkg::EX_EX_FWD_SEL :
			hazard_2b ? rv_pkg::MEM_EX_FWD_SEL : rv_pkg::RS_SEL;
		fwd_m2m = hazard_3 ? rv_pkg::MEM_MEM_FWD_SEL : rv_pkg::RS_SEL;
	end

	always_comb begin
		hazard_4a = (instr_x.opcode == rv_pkg::LOAD) && (instr_x.rd != rv_pkg::X0) &&
			(instr_x.rd == instr_d.rs1);
		// store data can wait for the mem - mem path
		hazard_4b = (instr_x.opcode == rv_pkg::LOAD) && (instr_x.rd != rv_pkg::X0) &&
			(instr_x.rd == instr_d.rs2) && (instr_d.opcode != rv_pkg::STORE);
		hazard_5a = mem_load && d_cmp && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_d.rs1);
		hazard_5b = mem_load && d_cmp && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_d.rs2);

		hazard_6a = d_cmp && (instr_x.rd != rv_pkg::X0) && (instr_x.rd == instr_d.rs1);
		hazard_6b = d_cmp && (instr_x.rd != rv_pkg::X0) && (instr_x.rd == instr_d.rs2);
		hazard_7a = d_cmp && !hazard_6a && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_d.rs1);
		hazard_7b = d_cmp && !hazard_6b && (ex_mem_rd != rv_pkg::X0) &&
			(ex_mem_rd == instr_d.rs2);
		hazard_8a = d_cmp && !hazard_6a && !hazard_7a && (mem_wb_rd != rv_pkg::X0) &&
			(mem_wb_rd == instr_d.rs1);
		hazard_8b = d_cmp && !hazard_6b && !hazard_7b && (mem_wb_rd != rv_pkg::X0) &&
			(mem_wb_rd == instr_d.rs2);
	end

	always_comb begin
		fwd_rs1 = hazard_6a ? rv_pkg::B_EX_SEL :
			hazard_7a ? rv_pkg::B_MEM_SEL :
			hazard_8a ? rv_pkg::B_WB_SEL : rv_pkg::B_RS_SEL;
		fwd_rs2 = hazard_6b ? rv_pkg::B_EX_SEL :
			hazard_7b ? rv_pkg::B_MEM_SEL :
			hazard_8b ? rv_pkg::B_WB_SEL : rv_pkg::B_RS_SEL;
	end

	assign stall_if_id = hazard_4a || hazard_4b || hazard_5a || hazard_5b;
	assign stall_id_ex = stall_if_id;

	// a stalled branch has stale operands, and an empty fetch slot has nothing to squash
	assign flush_if_id = (jump || branch_actual) && !stall_if_id &&
		(instr_f.opcode != rv_pkg::NOP);

endmodule : hazard_ctrl

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
	input  logic                clk,
	input  logic                arst_n,
	input  logic [31:0]         instr_word,
	input  logic [31:0]         if_pc,
	input  rv_pkg::branch_fwd_t fwd_rs1,
	input  rv_pkg::branch_fwd_t fwd_rs2,
	input  logic [31:0]         ex_result,
	input  logic [31:0]         mem_result,
	input  logic [31:0]         wb_result,
	input  rv_pkg::wb_pkt_t     wb,
	input  logic                stall_id_ex,
	output rv_pkg::instr_t      instr_d,
	output logic                branch_actual,
	output logic                redirect,
	output logic [31:0]         redirect_pc,
	output rv_pkg::ex_pkt_t     ex_pkt
);

	logic [31:0] rf [32];
	logic        wb_we;
	logic [31:0] rs1_rf;
	logic [31:0] rs2_rf;
	logic [31:0] br_a;
	logic [31:0] br_b;
	logic        jump;

	assign instr_d = rv_pkg::decode_instr(instr_word);

	assign wb_we = wb.valid && wb.wr_rd;	// wr_rd is already low for x0

	always_ff @(posedge clk) begin
		if (wb_we)
			rf[wb.instr.rd] <= wb.result;
	end

	// read through a write landing in the same cycle
	always_comb begin
		if (instr_d.rs1 == rv_pkg::X0)
			rs1_rf = '0;
		else if (wb_we && wb.instr.rd == instr_d.rs1)
			rs1_rf = wb.result;
		else
			rs1_rf = rf[instr_d.rs1];

		if (instr_d.rs2 == rv_pkg::X0)
			rs2_rf = '0;
		else if (wb_we && wb.instr.rd == instr_d.rs2)
			rs2_rf = wb.result;
		else
			rs2_rf = rf[instr_d.rs2];
	end

	always_comb begin
		case (fwd_rs1)
			rv_pkg::B_EX_SEL:  br_a = ex_result;
			rv_pkg::B_MEM_SEL: br_a = mem_result;
			rv_pkg::B_WB_SEL:  br_a = wb_result;
			default:           br_a = rs1_rf;
		endcase
		case (fwd_rs2)
			rv_pkg::B_EX_SEL:  br_b = ex_result;
			rv_pkg::B_MEM_SEL: br_b = mem_result;
			rv_pkg::B_WB_SEL:  br_b = wb_result;
			default:           br_b = rs2_rf;
		endcase
	end

	// beq / bne, predicted not taken
	assign branch_actual = (instr_d.opcode == rv_pkg::B) &&
		(instr_d.funct ? (br_a != br_b) : (br_a == br_b));

	assign jump = (instr_d.opcode == rv_pkg::JAL) || (instr_d.opcode == rv_pkg::JALR);
	assign redirect = jump || branch_actual;
	assign redirect_pc = (instr_d.opcode == rv_pkg::JALR) ?
		((br_a + instr_d.imm) & ~32'd1) : (if_pc + instr_d.imm);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ex_pkt <= '0;
		end else if (stall_id_ex) begin
			ex_pkt <= '0;	// bubble into execute
		end else begin
			ex_pkt.instr <= instr_d;
			ex_pkt.pc <= if_pc;
			ex_pkt.rs1_val <= rs1_rf;
			ex_pkt.rs2_val <= rs2_rf;
			ex_pkt.valid <= (instr_d.opcode != rv_pkg::NOP);
		end
	end

endmodule : decode_stage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_stage #(
	parameter int IMEM_WORDS = 64
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             imem_wr_valid,
	input  rv_pkg::imem_wr_t imem_wr,
	output logic             imem_wr_ready,
	input  logic             start,
	input  logic             stall_if_id,
	input  logic             flush_if_id,
	input  logic             redirect,
	input  logic [31:0]      redirect_pc,
	output logic [31:0]      instr_word,
	output logic [31:0]      if_pc,
	output rv_pkg::instr_t   instr_f
);

	localparam int IW = $clog2(IMEM_WORDS);

	typedef enum logic {IDLE, RUN} run_state_t;

	run_state_t  state;
	logic [31:0] pc;
	logic [31:0] f_word;
	logic [31:0] imem [IMEM_WORDS];

	assign imem_wr_ready = (state == IDLE);	// program load only before start

	always_ff @(posedge clk) begin
		if (imem_wr_valid && imem_wr_ready)
			imem[imem_wr.addr[IW-1:0]] <= imem_wr.instr;
	end

	// idle core fetches zeros, i.e. bubbles
	assign f_word = (state == RUN) ? imem[pc[IW+1:2]] : '0;
	assign instr_f = rv_pkg::decode_instr(f_word);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			pc <= '0;
			instr_word <= '0;
			if_pc <= '0;
		end else begin
			if (state == IDLE && start)
				state <= RUN;	// stays in run until reset
			if (state == RUN && !stall_if_id) begin
				pc <= redirect ? redirect_pc : pc + 32'd4;
				instr_word <= flush_if_id ? '0 : f_word;	// flush squashes wrong path
				if_pc <= pc;
			end
		end
	end

endmodule : fetch_stage

`default_nettype wire

//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

	// zero encodes NOP so an all-zero record is a bubble
	typedef enum logic [3:0] {
		NOP = 4'd0,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_ADDI,
		LOAD,
		STORE,
		B,
		JAL,
		JALR
	} opcode_t;

	typedef logic [4:0] r_t;
	localparam r_t X0 = 5'd0;

	typedef enum logic [1:0] {
		RS_SEL,
		EX_EX_FWD_SEL,
		MEM_EX_FWD_SEL,
		MEM_MEM_FWD_SEL
	} fwd_sel_t;

	typedef enum logic [1:0] {
		B_RS_SEL,
		B_EX_SEL,
		B_MEM_SEL,
		B_WB_SEL
	} branch_fwd_t;

	typedef struct packed {
		opcode_t     opcode;
		r_t          rd;	// x0 for stores and branches
		r_t          rs1;
		r_t          rs2;
		logic [31:0] imm;
		logic        funct;	// set for bne
	} instr_t;

	typedef struct packed {
		instr_t      instr;
		logic [31:0] pc;
		logic [31:0] rs1_val;
		logic [31:0] rs2_val;
		logic        valid;
	} ex_pkt_t;

	typedef struct packed {
		instr_t      instr;
		logic [31:0] pc;	// carried along for the retire record
		logic [31:0] alu_out;
		logic [31:0] store_val;
		logic        wr_rd;
		logic        valid;
	} mem_pkt_t;

	typedef struct packed {
		instr_t      instr;
		logic [31:0] result;
		logic        wr_rd;
		logic        valid;
	} wb_pkt_t;

	typedef struct packed {
		logic        kind;	// 1 = store, 0 = register write
		logic [31:0] index;	// rd or word address
		logic [31:0] value;
		logic [31:0] pc;
	} retire_t;

	typedef struct packed {
		logic [31:0] addr;	// word address
		logic [31:0] instr;
	} imem_wr_t;

	// RV32I subset; anything unsupported comes back as a bubble
	function automatic instr_t decode_instr(input logic [31:0] w);
		instr_t      d;
		logic [2:0]  f3;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_j;
		d = '0;
		f3 = w[14:12];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		d.rd = w[11:7];
		d.rs1 = w[19:15];
		d.rs2 = w[24:20];
		case (w[6:0])
			7'b0110011: begin
				if (f3 == 3'b000)
					d.opcode = w[30] ? OP_SUB : OP_ADD;
				else if (f3 == 3'b111)
					d.opcode = OP_AND;
				else if (f3 == 3'b110)
					d.opcode = OP_OR;
			end
			7'b0010011: if (f3 == 3'b000) d.opcode = OP_ADDI;
			7'b0000011: if (f3 == 3'b010) d.opcode = LOAD;
			7'b0100011: if (f3 == 3'b010) d.opcode = STORE;
			7'b1100011: if (f3[2:1] == 2'b00) d.opcode = B;
			7'b1101111: d.opcode = JAL;
			7'b1100111: if (f3 == 3'b000) d.opcode = JALR;
			default: d.opcode = NOP;
		endcase
		case (d.opcode)
			OP_ADDI, LOAD, JALR: d.imm = imm_i;
			STORE: d.imm = imm_s;
			B: d.imm = imm_b;
			JAL: d.imm = imm_j;
			default: d.imm = '0;
		endcase
		// unused fields go to x0 so hazard matching stays exact
		if (d.opcode inside {OP_ADDI, LOAD, JAL, JALR})
			d.rs2 = X0;
		if (d.opcode == JAL)
			d.rs1 = X0;
		if (d.opcode inside {STORE, B})
			d.rd = X0;
		d.funct = (d.opcode == B) && f3[0];
		if (d.opcode == NOP)
			d = '0;
		return d;
	endfunction

endpackage : rv_pkg

`default_nettype wire
